//--- verilog.f
mem_stage_pkg.sv
mem_lane_unit.sv
mem_access_stage.sv
apb_bus_bridge.sv
apb_word_ram.sv
mem_subsystem_top.sv
tb_mem_subsystem.sv

//--- Makefile
TOP = tb_mem_subsystem

.PHONY: all lint clean

all:
	verilator --binary --timing -Wno-fatal --top-module $(TOP) -f verilog.f -o sim
	@out="$$(./obj_dir/sim)"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "TEST PASS"

lint:
	verilator --lint-only --timing --top-module $(TOP) -f verilog.f

clean:
	rm -rf obj_dir

//--- tb_mem_subsystem.sv
`timescale 1ns/10ps

module tb_mem_subsystem;
	import mem_stage_pkg::*;

	localparam int RAM_WORDS   = 256;
	localparam int WAIT_STATES = 1;
	localparam int TIMEOUT     = 100;
	// Small window so random loads hit earlier stores.
	localparam int MIX_WORDS   = 16;

	typedef struct packed {
		logic [TAG_W-1:0]    tag;
		logic [RD_IDX_W-1:0] inst_rd;
		logic                branch;
		logic [DATA_W-1:0]   pc_next;
		logic                has_rd;
		logic [DATA_W-1:0]   rd;
	} expect_t;

	logic                i_clock = 1'b0;
	logic                i_rst_n;
	logic [TAG_W-1:0]    i_tag;
	logic [RD_IDX_W-1:0] i_inst_rd;
	logic [DATA_W-1:0]   i_rd;
	logic                i_branch;
	logic [DATA_W-1:0]   i_pc_next;
	logic                i_mem_read;
	logic                i_mem_write;
	mem_width_t          i_mem_width;
	logic                i_mem_signed;
	logic [DATA_W-1:0]   i_mem_address;

	logic [TAG_W-1:0]    o_tag;
	logic [RD_IDX_W-1:0] o_inst_rd;
	logic [DATA_W-1:0]   o_rd;
	logic                o_branch;
	logic [DATA_W-1:0]   o_pc_next;
	logic                o_stall;

	logic [DATA_W-1:0] shadow [RAM_WORDS];
	expect_t           expect_q[$];
	logic [TAG_W-1:0]  cur_tag;
	logic [TAG_W-1:0]  seen_tag;
	integer            seed;
	int                check_count;
	int                error_count;
	int                test_checks;
	int                test_errors;

	mem_subsystem_top #(
		.RAM_WORDS   (RAM_WORDS),
		.WAIT_STATES (WAIT_STATES)
	) u_dut (
		.i_clock       (i_clock),
		.i_rst_n       (i_rst_n),
		.i_tag         (i_tag),
		.i_inst_rd     (i_inst_rd),
		.i_rd          (i_rd),
		.i_branch      (i_branch),
		.i_pc_next     (i_pc_next),
		.i_mem_read    (i_mem_read),
		.i_mem_write   (i_mem_write),
		.i_mem_width   (i_mem_width),
		.i_mem_signed  (i_mem_signed),
		.i_mem_address (i_mem_address),
		.o_tag         (o_tag),
		.o_inst_rd     (o_inst_rd),
		.o_rd          (o_rd),
		.o_branch      (o_branch),
		.o_pc_next     (o_pc_next),
		.o_stall       (o_stall)
	);

	always #5 i_clock = ~i_clock;

	// Expected load result from a shadow word.
	function automatic logic [DATA_W-1:0] load_expect(
		input logic [DATA_W-1:0] word,
		input logic [1:0]        off,
		input mem_width_t        width,
		input logic              sgn
	);
		logic [7:0]  b;
		logic [15:0] h;
		case (off)
			2'd0:    b = word[7:0];
			2'd1:    b = word[15:8];
			2'd2:    b = word[23:16];
			default: b = word[31:24];
		endcase
		h = off[1] ? word[31:16] : word[15:0];
		case (width)
			MEM_BYTE: return sgn ? {{24{b[7]}}, b} : {24'h0, b};
			MEM_HALF: return sgn ? {{16{h[15]}}, h} : {16'h0, h};
			default:  return word;
		endcase
	endfunction

	// Shadow word after a store of the given width.
	function automatic logic [DATA_W-1:0] store_merge(
		input logic [DATA_W-1:0] old,
		input logic [DATA_W-1:0] value,
		input logic [1:0]        off,
		input mem_width_t        width
	);
		logic [DATA_W-1:0] w;
		w = old;
		case (width)
			MEM_BYTE: begin
				case (off)
					2'd0:    w[7:0] = value[7:0];
					2'd1:    w[15:8] = value[7:0];
					2'd2:    w[23:16] = value[7:0];
					default: w[31:24] = value[7:0];
				endcase
			end
			MEM_HALF: begin
				if (off[1])
					w[31:16] = value[15:0];
				else
					w[15:0] = value[15:0];
			end
			default: w = value;
		endcase
		return w;
	endfunction

	task automatic check_data(input string name, input logic [DATA_W-1:0] exp,
		input logic [DATA_W-1:0] act);
		check_count++;
		if (act !== exp) begin
			error_count++;
			$display("Mismatch at %0t: %s expected %h, actual %h", $time, name, exp, act);
		end
	endtask

	task automatic check_tag(input string name, input logic [TAG_W-1:0] exp,
		input logic [TAG_W-1:0] act);
		check_count++;
		if (act !== exp) begin
			error_count++;
			$display("Mismatch at %0t: %s expected %h, actual %h", $time, name, exp, act);
		end
	endtask

	task automatic check_idx(input string name, input logic [RD_IDX_W-1:0] exp,
		input logic [RD_IDX_W-1:0] act);
		check_count++;
		if (act !== exp) begin
			error_count++;
			$display("Mismatch at %0t: %s expected %h, actual %h", $time, name, exp, act);
		end
	endtask

	task automatic check_flag(input string name, input logic exp, input logic act);
		check_count++;
		if (act !== exp) begin
			error_count++;
			$display("Mismatch at %0t: %s expected %b, actual %b", $time, name, exp, act);
		end
	endtask

	// Each new output tag is compared with the oldest expectation.
	always @(negedge i_clock) begin
		expect_t e;
		if (i_rst_n && (o_tag != seen_tag)) begin
			seen_tag = o_tag;
			if (expect_q.size() == 0) begin
				error_count++;
				$display("Tag %0d completed at %0t without an issued instruction", o_tag, $time);
			end else begin
				e = expect_q.pop_front();
				check_tag("o_tag", e.tag, o_tag);
				check_idx("o_inst_rd", e.inst_rd, o_inst_rd);
				check_flag("o_branch", e.branch, o_branch);
				check_data("o_pc_next", e.pc_next, o_pc_next);
				if (e.has_rd)
					check_data("o_rd", e.rd, o_rd);
			end
		end
	end

	task automatic issue_inst(
		input logic              rd_flag,
		input logic              wr_flag,
		input mem_width_t        width,
		input logic              sgn,
		input logic [DATA_W-1:0] addr,
		input logic [DATA_W-1:0] value,
		input logic              has_rd,
		input logic [DATA_W-1:0] exp_rd
	);
		expect_t     e;
		logic [31:0] r;
		int          cycles;
		cur_tag = cur_tag + 1'b1;
		// Tag 0 is the reset value of the output tag.
		if (cur_tag == '0)
			cur_tag = TAG_W'(1);
		r = $random(seed);
		e.tag = cur_tag;
		e.inst_rd = r[4:0];
		e.branch = r[5];
		e.pc_next = $random(seed);
		e.has_rd = has_rd;
		e.rd = exp_rd;
		expect_q.push_back(e);
		@(posedge i_clock);
		i_tag         <= cur_tag;
		i_inst_rd     <= e.inst_rd;
		i_rd          <= value;
		i_branch      <= e.branch;
		i_pc_next     <= e.pc_next;
		i_mem_read    <= rd_flag;
		i_mem_write   <= wr_flag;
		i_mem_width   <= width;
		i_mem_signed  <= sgn;
		i_mem_address <= addr;
		@(negedge i_clock);
		cycles = 0;
		while ((o_tag !== cur_tag) && (cycles < TIMEOUT)) begin
			// Stall stays up for every cycle of a pending access.
			check_flag("o_stall", rd_flag || wr_flag, o_stall);
			@(negedge i_clock);
			cycles++;
		end
		if (o_tag !== cur_tag) begin
			$display("Instruction with tag %0d never completed within %0d cycles",
				cur_tag, TIMEOUT);
			$display("TEST FAIL");
			$finish;
		end
	endtask

	task automatic alu_op(input logic [DATA_W-1:0] value);
		issue_inst(1'b0, 1'b0, MEM_WORD, 1'b0, '0, value, 1'b1, value);
	endtask

	task automatic store_op(input int idx, input logic [1:0] off, input mem_width_t width,
		input logic [DATA_W-1:0] value);
		shadow[idx] = store_merge(shadow[idx], value, off, width);
		issue_inst(1'b0, 1'b1, width, 1'b0, DATA_W'(idx * 4 + int'(off)), value, 1'b0, '0);
	endtask

	task automatic load_op(input int idx, input logic [1:0] off, input mem_width_t width,
		input logic sgn);
		logic [DATA_W-1:0] exp;
		exp = load_expect(shadow[idx], off, width, sgn);
		issue_inst(1'b1, 1'b0, width, sgn, DATA_W'(idx * 4 + int'(off)), '0, 1'b1, exp);
	endtask

	task automatic report_test(input string name);
		int errs;
		@(posedge i_clock);
		errs = error_count - test_errors;
		$display("%-16s %s, checks %0d, errors %0d", name, (errs == 0) ? "ok" : "failed",
			check_count - test_checks, errs);
		test_checks = check_count;
		test_errors = error_count;
	endtask

	initial begin
		int          i;
		int          j;
		int          s;
		int          idx;
		logic [31:0] r;
		logic [31:0] d;
		mem_width_t  width;
		logic [1:0]  off;

		seed = 64;
		cur_tag = '0;
		seen_tag = '0;
		check_count = 0;
		error_count = 0;
		test_checks = 0;
		test_errors = 0;
		for (i = 0; i < RAM_WORDS; i++)
			shadow[i] = '0;
		i_rst_n = 1'b0;
		i_tag = '0;
		i_inst_rd = '0;
		i_rd = '0;
		i_branch = 1'b0;
		i_pc_next = '0;
		i_mem_read = 1'b0;
		i_mem_write = 1'b0;
		i_mem_width = MEM_WORD;
		i_mem_signed = 1'b0;
		i_mem_address = '0;

		repeat (4) @(posedge i_clock);
		i_rst_n <= 1'b1;
		@(negedge i_clock);
		check_tag("o_tag", '0, o_tag);
		check_data("o_rd", '0, o_rd);
		check_flag("o_stall", 1'b0, o_stall);
		report_test("reset");

		alu_op(32'h1234_5678);
		alu_op(32'hdead_beef);
		alu_op(32'h0000_0000);
		report_test("passthrough");

		for (i = 0; i < 3; i++) begin
			d = $random(seed);
			store_op(3 + i, 2'd0, MEM_WORD, d);
			load_op(3 + i, 2'd0, MEM_WORD, 1'b0);
		end
		store_op(RAM_WORDS - 1, 2'd0, MEM_WORD, 32'hcafe_f00d);
		load_op(RAM_WORDS - 1, 2'd0, MEM_WORD, 1'b0);
		report_test("word store/load");

		store_op(40, 2'd0, MEM_WORD, 32'h1122_3344);
		for (i = 0; i < 4; i++) begin
			d = $random(seed);
			store_op(40, i[1:0], MEM_BYTE, d);
			load_op(40, 2'd0, MEM_WORD, 1'b0);
		end
		store_op(41, 2'd0, MEM_WORD, 32'h5566_7788);
		for (i = 0; i < 2; i++) begin
			d = $random(seed);
			store_op(41, {i[0], 1'b0}, MEM_HALF, d);
			load_op(41, 2'd0, MEM_WORD, 1'b0);
		end
		report_test("sub-word stores");

		// Sign bits set in some lanes and clear in others.
		store_op(50, 2'd0, MEM_WORD, 32'h80ff_7f01);
		store_op(51, 2'd0, MEM_WORD, 32'h7f80_ff00);
		for (i = 50; i < 52; i++) begin
			for (s = 0; s < 2; s++) begin
				for (j = 0; j < 4; j++)
					load_op(i, j[1:0], MEM_BYTE, s[0]);
				load_op(i, 2'd0, MEM_HALF, s[0]);
				load_op(i, 2'd2, MEM_HALF, s[0]);
			end
		end
		report_test("sub-word loads");

		for (i = 0; i < 200; i++) begin
			r = $random(seed);
			d = $random(seed);
			idx = int'(r[15:8]) % MIX_WORDS;
			case (r[3:2])
				2'd0: begin
					width = MEM_BYTE;
					off = r[5:4];
				end
				2'd1: begin
					width = MEM_HALF;
					off = {r[4], 1'b0};
				end
				default: begin
					width = MEM_WORD;
					off = 2'd0;
				end
			endcase
			case (r[1:0])
				2'd0:    alu_op(d);
				2'd2:    store_op(idx, off, width, d);
				default: load_op(idx, off, width, r[6]);
			endcase
		end
		report_test("random mix");

		if (expect_q.size() != 0) begin
			error_count++;
			$display("%0d issued instructions were never reported complete", expect_q.size());
		end
		$display("Total checks %0d, errors %0d", check_count, error_count);
		if (error_count == 0)
			$display("TEST PASS");
		else
			$display("TEST FAIL");
		$finish;
	end

endmodule

//--- mem_subsystem_top.sv
`timescale 1ns/10ps

module mem_subsystem_top #(
	parameter int RAM_WORDS   = 256,
	parameter int WAIT_STATES = 1
) (
	input  logic                               i_clock,
	input  logic                               i_rst_n,

	input  logic [mem_stage_pkg::TAG_W-1:0]    i_tag,
	input  logic [mem_stage_pkg::RD_IDX_W-1:0] i_inst_rd,
	input  logic [mem_stage_pkg::DATA_W-1:0]   i_rd,
	input  logic                               i_branch,
	input  logic [mem_stage_pkg::DATA_W-1:0]   i_pc_next,
	input  logic                               i_mem_read,
	input  logic                               i_mem_write,
	input  mem_stage_pkg::mem_width_t          i_mem_width,
	input  logic                               i_mem_signed,
	input  logic [mem_stage_pkg::DATA_W-1:0]   i_mem_address,

	output logic [mem_stage_pkg::TAG_W-1:0]    o_tag,
	output logic [mem_stage_pkg::RD_IDX_W-1:0] o_inst_rd,
	output logic [mem_stage_pkg::DATA_W-1:0]   o_rd,
	output logic                               o_branch,
	output logic [mem_stage_pkg::DATA_W-1:0]   o_pc_next,
	output logic                               o_stall
);
	import mem_stage_pkg::*;

	logic              bus_request;
	logic              bus_rw;
	logic              bus_ready;
	logic [DATA_W-1:0] bus_address;
	logic [DATA_W-1:0] bus_wdata;
	logic [DATA_W-1:0] bus_rdata;

	logic              psel;
	logic              penable;
	logic              pwrite;
	logic              pready;
	logic [DATA_W-1:0] paddr;
	logic [DATA_W-1:0] pwdata;
	logic [DATA_W-1:0] prdata;

	mem_access_stage u_stage (
		.i_clock       (i_clock),
		.i_rst_n       (i_rst_n),
		.i_tag         (i_tag),
		.i_inst_rd     (i_inst_rd),
		.i_rd          (i_rd),
		.i_branch      (i_branch),
		.i_pc_next     (i_pc_next),
		.i_mem_read    (i_mem_read),
		.i_mem_write   (i_mem_write),
		.i_mem_width   (i_mem_width),
		.i_mem_signed  (i_mem_signed),
		.i_mem_address (i_mem_address),
		.i_bus_ready   (bus_ready),
		.i_bus_rdata   (bus_rdata),
		.o_bus_request (bus_request),
		.o_bus_rw      (bus_rw),
		.o_bus_address (bus_address),
		.o_bus_wdata   (bus_wdata),
		.o_tag         (o_tag),
		.o_inst_rd     (o_inst_rd),
		.o_rd          (o_rd),
		.o_branch      (o_branch),
		.o_pc_next     (o_pc_next),
		.o_stall       (o_stall)
	);

	apb_bus_bridge u_bridge (
		.i_clock   (i_clock),
		.i_rst_n   (i_rst_n),
		.i_request (bus_request),
		.i_rw      (bus_rw),
		.i_address (bus_address),
		.i_wdata   (bus_wdata),
		.o_ready   (bus_ready),
		.o_rdata   (bus_rdata),
		.o_psel    (psel),
		.o_penable (penable),
		.o_pwrite  (pwrite),
		.o_paddr   (paddr),
		.o_pwdata  (pwdata),
		.i_prdata  (prdata),
		.i_pready  (pready)
	);

	apb_word_ram #(
		.RAM_WORDS   (RAM_WORDS),
		.WAIT_STATES (WAIT_STATES)
	) u_ram (
		.i_clock   (i_clock),
		.i_rst_n   (i_rst_n),
		.i_psel    (psel),
		.i_penable (penable),
		.i_pwrite  (pwrite),
		.i_paddr   (paddr),
		.i_pwdata  (pwdata),
		.o_prdata  (prdata),
		.o_pready  (pready)
	);

endmodule

//--- apb_word_ram.sv
`timescale 1ns/10ps

module apb_word_ram #(
	parameter int RAM_WORDS   = 256,
	parameter int WAIT_STATES = 1
) (
	input  logic                             i_clock,
	input  logic                             i_rst_n,
	input  logic                             i_psel,
	input  logic                             i_penable,
	input  logic                             i_pwrite,
	input  logic [mem_stage_pkg::DATA_W-1:0] i_paddr,
	input  logic [mem_stage_pkg::DATA_W-1:0] i_pwdata,
	output logic [mem_stage_pkg::DATA_W-1:0] o_prdata,
	output logic                             o_pready
);
	import mem_stage_pkg::*;

	localparam int IDX_W = (RAM_WORDS > 1) ? $clog2(RAM_WORDS) : 1;
	localparam int CNT_W = (WAIT_STATES > 0) ? $clog2(WAIT_STATES + 1) : 1;

	logic [DATA_W-1:0] mem [RAM_WORDS];
	logic [IDX_W-1:0]  word_idx;
	logic [CNT_W-1:0]  wait_cnt;
	logic              access;

	// Byte address wraps onto the word array.
	assign word_idx = IDX_W'((i_paddr >> 2) % RAM_WORDS);

	assign access = i_psel && i_penable;
	assign o_pready = access && (wait_cnt == CNT_W'(WAIT_STATES));

	always_ff @(posedge i_clock or negedge i_rst_n) begin
		if (!i_rst_n)
			wait_cnt <= '0;
		else if (!access || o_pready)
			wait_cnt <= '0;
		else
			wait_cnt <= wait_cnt + 1'b1;
	end

	initial begin
		for (int i = 0; i < RAM_WORDS; i++)
			mem[i] = '0;
	end

	// Read data is fetched in the setup phase.
	always @(posedge i_clock) begin
		if (o_pready && i_pwrite)
			mem[word_idx] <= i_pwdata;
		if (i_psel && !i_penable)
			o_prdata <= mem[word_idx];
	end

endmodule

//--- apb_bus_bridge.sv
`timescale 1ns/10ps

module apb_bus_bridge (
	input  logic                             i_clock,
	input  logic                             i_rst_n,

	input  logic                             i_request,
	input  logic                             i_rw,
	input  logic [mem_stage_pkg::DATA_W-1:0] i_address,
	input  logic [mem_stage_pkg::DATA_W-1:0] i_wdata,
	output logic                             o_ready,
	output logic [mem_stage_pkg::DATA_W-1:0] o_rdata,

	output logic                             o_psel,
	output logic                             o_penable,
	output logic                             o_pwrite,
	output logic [mem_stage_pkg::DATA_W-1:0] o_paddr,
	output logic [mem_stage_pkg::DATA_W-1:0] o_pwdata,
	input  logic [mem_stage_pkg::DATA_W-1:0] i_prdata,
	input  logic                             i_pready
);
	typedef enum logic [1:0] {
		PH_IDLE   = 2'd0,
		PH_SETUP  = 2'd1,
		PH_ACCESS = 2'd2
	} phase_t;

	phase_t phase;

	// One ready pulse, then back to idle.
	assign o_ready = (phase == PH_ACCESS) && i_pready;
	assign o_rdata = i_prdata;

	always_ff @(posedge i_clock or negedge i_rst_n) begin
		if (!i_rst_n) begin
			phase     <= PH_IDLE;
			o_psel    <= 1'b0;
			o_penable <= 1'b0;
			o_pwrite  <= 1'b0;
			o_paddr   <= '0;
		end else begin
			case (phase)
				PH_IDLE: begin
					if (i_request) begin
						phase    <= PH_SETUP;
						o_psel   <= 1'b1;
						o_pwrite <= i_rw;
						o_paddr  <= i_address;
					end
				end
				PH_SETUP: begin
					phase     <= PH_ACCESS;
					o_penable <= 1'b1;
				end
				PH_ACCESS: begin
					if (i_pready) begin
						phase     <= PH_IDLE;
						o_psel    <= 1'b0;
						o_penable <= 1'b0;
					end
				end
				default: phase <= PH_IDLE;
			endcase
		end
	end

	always_ff @(posedge i_clock) begin
		if ((phase == PH_IDLE) && i_request)
			o_pwdata <= i_wdata;
	end

	// The stage must hold its request through the whole access phase.
	a_penable_with_psel: assert property (@(posedge i_clock) disable iff (!i_rst_n)
		o_penable |-> (o_psel && i_request))
		else $error("PENABLE without PSEL or a held request");

endmodule

//--- mem_access_stage.sv
`timescale 1ns/10ps

module mem_access_stage (
	input  logic                               i_clock,
	input  logic                               i_rst_n,

	input  logic [mem_stage_pkg::TAG_W-1:0]    i_tag,
	input  logic [mem_stage_pkg::RD_IDX_W-1:0] i_inst_rd,
	input  logic [mem_stage_pkg::DATA_W-1:0]   i_rd,
	input  logic                               i_branch,
	input  logic [mem_stage_pkg::DATA_W-1:0]   i_pc_next,
	input  logic                               i_mem_read,
	input  logic                               i_mem_write,
	input  mem_stage_pkg::mem_width_t          i_mem_width,
	input  logic                               i_mem_signed,
	input  logic [mem_stage_pkg::DATA_W-1:0]   i_mem_address,

	input  logic                               i_bus_ready,
	input  logic [mem_stage_pkg::DATA_W-1:0]   i_bus_rdata,
	output logic                               o_bus_request,
	output logic                               o_bus_rw,
	output logic [mem_stage_pkg::DATA_W-1:0]   o_bus_address,
	output logic [mem_stage_pkg::DATA_W-1:0]   o_bus_wdata,

	output logic [mem_stage_pkg::TAG_W-1:0]    o_tag,
	output logic [mem_stage_pkg::RD_IDX_W-1:0] o_inst_rd,
	output logic [mem_stage_pkg::DATA_W-1:0]   o_rd,
	output logic                               o_branch,
	output logic [mem_stage_pkg::DATA_W-1:0]   o_pc_next,
	output logic                               o_stall
);
	import mem_stage_pkg::*;

	stage_state_t      state;
	logic              new_inst;
	logic              mem_access;
	logic [DATA_W-1:0] lane_load;
	logic [DATA_W-1:0] lane_store;
	logic [DATA_W-1:0] rmw_word;

	assign new_inst = (i_tag != o_tag);
	assign mem_access = i_mem_read || i_mem_write;

	// Hold the pipeline until the access finishes.
	assign o_stall = new_inst && mem_access;

	// Request drops in the release cycle between the RMW read and write.
	assign o_bus_request = o_stall && (state != ST_RMW_RELEASE);
	assign o_bus_rw = i_mem_write && ((i_mem_width == MEM_WORD) || (state == ST_RMW_WRITE));
	assign o_bus_address = {i_mem_address[DATA_W-1:2], 2'b00};
	assign o_bus_wdata = (state == ST_RMW_WRITE) ? rmw_word : i_rd;

	mem_lane_unit u_lane (
		.i_word       (i_bus_rdata),
		.i_reg        (i_rd),
		.i_byte_idx   (i_mem_address[1:0]),
		.i_width      (i_mem_width),
		.i_signed     (i_mem_signed),
		.o_load       (lane_load),
		.o_store_word (lane_store)
	);

	always_ff @(posedge i_clock or negedge i_rst_n) begin
		if (!i_rst_n) begin
			state     <= ST_IDLE;
			o_tag     <= '0;
			o_inst_rd <= '0;
			o_rd      <= '0;
			o_branch  <= 1'b0;
			o_pc_next <= '0;
		end else begin
			case (state)
				ST_IDLE: begin
					if (new_inst) begin
						o_inst_rd <= i_inst_rd;
						o_branch  <= i_branch;
						o_pc_next <= i_pc_next;
						if (i_mem_read) begin
							if (i_bus_ready) begin
								o_rd  <= lane_load;
								o_tag <= i_tag;
							end
						end else if (i_mem_write) begin
							if (i_mem_width == MEM_WORD) begin
								if (i_bus_ready)
									o_tag <= i_tag;
							end else begin
								state <= ST_RMW_READ;
							end
						end else begin
							// Plain ALU result.
							o_rd  <= i_rd;
							o_tag <= i_tag;
						end
					end
				end

				ST_RMW_READ: begin
					if (i_bus_ready)
						state <= ST_RMW_RELEASE;
				end

				ST_RMW_RELEASE: begin
					state <= ST_RMW_WRITE;
				end

				ST_RMW_WRITE: begin
					if (i_bus_ready) begin
						o_tag <= i_tag;
						state <= ST_IDLE;
					end
				end

				default: state <= ST_IDLE;
			endcase
		end
	end

	// Merged word for the write half of the RMW.
	always_ff @(posedge i_clock) begin
		if ((state == ST_RMW_READ) && i_bus_ready)
			rmw_word <= lane_store;
	end

	a_half_aligned: assert property (@(posedge i_clock) disable iff (!i_rst_n)
		(o_stall && (i_mem_width == MEM_HALF)) |-> !i_mem_address[0])
		else $error("Misaligned halfword access");

	a_word_aligned: assert property (@(posedge i_clock) disable iff (!i_rst_n)
		(o_stall && (i_mem_width == MEM_WORD)) |-> (i_mem_address[1:0] == 2'b00))
		else $error("Misaligned word access");

	a_read_write_excl: assert property (@(posedge i_clock) disable iff (!i_rst_n)
		new_inst |-> !(i_mem_read && i_mem_write))
		else $error("Read and write set together");

endmodule

//--- mem_lane_unit.sv
`timescale 1ns/10ps

module mem_lane_unit (
	input  logic [mem_stage_pkg::DATA_W-1:0] i_word,
	input  logic [mem_stage_pkg::DATA_W-1:0] i_reg,
	input  logic [1:0]                       i_byte_idx,
	input  mem_stage_pkg::mem_width_t        i_width,
	input  logic                             i_signed,
	output logic [mem_stage_pkg::DATA_W-1:0] o_load,
	output logic [mem_stage_pkg::DATA_W-1:0] o_store_word
);
	import mem_stage_pkg::*;

	logic [4:0]        shift;
	logic [DATA_W-1:0] shifted;
	logic [DATA_W-1:0] lane_mask;

	// Bit offset of the addressed lane.
	assign shift = {i_byte_idx, 3'b000};
	assign shifted = i_word >> shift;

	// Load extraction and extension.
	always_comb begin
		case (i_width)
			MEM_BYTE: o_load = {{(DATA_W-8){i_signed & shifted[7]}}, shifted[7:0]};
			MEM_HALF: o_load = {{(DATA_W-16){i_signed & shifted[15]}}, shifted[15:0]};
			default:  o_load = i_word;
		endcase
	end

	always_comb begin
		case (i_width)
			MEM_BYTE: lane_mask = DATA_W'(32'h0000_00ff) << shift;
			MEM_HALF: lane_mask = DATA_W'(32'h0000_ffff) << shift;
			default:  lane_mask = '1;
		endcase
	end

	// Untouched lanes keep the read word.
	assign o_store_word = (i_word & ~lane_mask) | ((i_reg << shift) & lane_mask);

endmodule

//--- mem_stage_pkg.sv
package mem_stage_pkg;

	// Datapath and address width.
	localparam int DATA_W = 32;

	// Instruction tag width.
	localparam int TAG_W = 8;

	// Destination register index width.
	localparam int RD_IDX_W = 5;

	// Access size, encoded as the number of bytes.
	typedef enum logic [2:0] {
		MEM_BYTE = 3'd1,
		MEM_HALF = 3'd2,
		MEM_WORD = 3'd4
	} mem_width_t;

	// Memory stage sequencer.
	// Loads and word stores complete from idle.
	// Sub-word stores walk through the RMW states.
	typedef enum logic [1:0] {
		ST_IDLE        = 2'd0,
		ST_RMW_READ    = 2'd1,
		ST_RMW_RELEASE = 2'd2,
		ST_RMW_WRITE   = 2'd3
	} stage_state_t;

endpackage
